//--- verilog/resize_pkg.sv
package resize_pkg;

    // ======================================================================
    // frame geometry
    // ======================================================================

    // source frame, scaled down from the camera size
    localparam int src_w = 64;
    localparam int src_h = 48;

    // averaging block
    localparam int blk_w = 8;
    localparam int blk_h = 6;

    // output grid, one byte per block
    localparam int out_w     = src_w / blk_w;
    localparam int out_h     = src_h / blk_h;
    localparam int out_count = out_w * out_h;
    localparam int blk_area  = blk_w * blk_h;

    // bus and counter widths
    localparam int addr_bits = 12;
    // 48 x 255 fits in 14 bits
    localparam int sum_bits  = 14;
    localparam int col_bits  = $clog2(src_w);
    localparam int row_bits  = $clog2(src_h);
    localparam int bcol_bits = $clog2(out_w);
    localparam int brow_bits = $clog2(out_h);
    localparam int idx_bits  = $clog2(out_count);

    // one pixel tagged with its raster position
    typedef struct packed {
        logic [7:0]          data;
        logic [col_bits-1:0] col;
        logic [row_bits-1:0] row;
    } pix_beat_t;

    // one averaged block, row-major index
    typedef struct packed {
        logic [idx_bits-1:0] idx;
        logic [7:0]          value;
    } res_wr_t;

endpackage

//--- verilog/frame_reader.sv
module frame_reader (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             key_n,
    input  logic [7:0]                       read_data,
    output logic                             read_en,
    output logic [resize_pkg::addr_bits-1:0] read_addr,
    output resize_pkg::pix_beat_t            beat,
    output logic                             pix_valid,
    output logic                             frame_loaded
);
    import resize_pkg::*;

    // set by the first key press and cleared only by reset
    logic                started;
    // raster position of the address being issued
    logic [col_bits-1:0] col_cnt;
    logic [row_bits-1:0] row_cnt;
    logic                last_addr;
    // position tags one cycle behind the address
    logic [col_bits-1:0] tag_col;
    logic [row_bits-1:0] tag_row;
    logic                tag_valid;
    logic                tag_last;

    assign last_addr = (col_cnt == col_bits'(src_w - 1)) &&
                       (row_cnt == row_bits'(src_h - 1));

    // src_w is a power of two, so row and column simply concatenate
    assign read_addr = {row_cnt, col_cnt};

    // ======================================================================
    // address generation
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
            read_en <= 1'b0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (!key_n && !started) begin
            // first address goes out on the key press edge
            started <= 1'b1;
            read_en <= 1'b1;
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (read_en) begin
            if (last_addr) begin
                // whole frame issued
                read_en <= 1'b0;
            end else if (col_cnt == col_bits'(src_w - 1)) begin
                // wrap to next line
                col_cnt <= '0;
                row_cnt <= row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // position tags and pixel data
    always_ff @(posedge clk) begin
        tag_col <= col_cnt;
        tag_row <= row_cnt;
        // memory answers one cycle after the address
        beat    <= '{data: read_data, col: tag_col, row: tag_row};
    end

    // valid pipeline matching the data path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid    <= 1'b0;
            tag_last     <= 1'b0;
            pix_valid    <= 1'b0;
            frame_loaded <= 1'b0;
        end else begin
            tag_valid <= read_en;
            tag_last  <= read_en && last_addr;
            pix_valid <= tag_valid;
            // rises with the final beat
            if (tag_last) begin
                frame_loaded <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/block_averager.sv
module block_averager (
    input  logic                  clk,
    input  logic                  rst_n,
    input  resize_pkg::pix_beat_t beat,
    input  logic                  pix_valid,
    output resize_pkg::res_wr_t   wr,
    output logic                  wr_valid,
    output logic                  avg_done
);
    import resize_pkg::*;

    // one running sum per block column of the current block row
    logic [sum_bits-1:0]  sums [out_w];

    // position of the beat inside the block grid
    logic [bcol_bits-1:0] blk_col;
    logic [brow_bits-1:0] blk_row;
    logic [col_bits-1:0]  sub_col;
    logic [row_bits-1:0]  sub_row;
    logic                 first_px;
    logic                 last_px;

    // sum including the current pixel and its average
    logic [sum_bits-1:0]  blk_total;
    logic [7:0]           blk_avg;

    // ======================================================================
    // beat decode
    // ======================================================================
    always_comb begin
        blk_col  = bcol_bits'(beat.col / blk_w);
        sub_col  = col_bits'(beat.col % blk_w);
        // block height is not a power of two
        blk_row  = brow_bits'(beat.row / blk_h);
        sub_row  = row_bits'(beat.row % blk_h);
        first_px = (sub_row == '0) && (sub_col == '0);
        last_px  = (sub_row == row_bits'(blk_h - 1)) &&
                   (sub_col == col_bits'(blk_w - 1));
        blk_total = sums[blk_col] + sum_bits'(beat.data);
        // floor division by the block area
        blk_avg   = 8'(blk_total / blk_area);
    end

    // ======================================================================
    // accumulation
    // ======================================================================
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            if (first_px) begin
                // top-left pixel starts a fresh sum
                sums[blk_col] <= sum_bits'(beat.data);
            end else if (!last_px) begin
                sums[blk_col] <= blk_total;
            end
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (pix_valid && last_px) begin
            wr.idx   <= idx_bits'(blk_row * out_w + blk_col);
            wr.value <= blk_avg;
        end
    end

    // write strobe and completion flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
            avg_done <= 1'b0;
        end else begin
            wr_valid <= pix_valid && last_px;
            // held from the last block write until reset
            if (wr_valid && (wr.idx == idx_bits'(out_count - 1))) begin
                avg_done <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/result_buffer.sv
module result_buffer (
    input  logic                            clk,
    input  resize_pkg::res_wr_t             wr,
    input  logic                            wr_valid,
    input  logic [resize_pkg::idx_bits-1:0] rd_idx,
    output logic [7:0]                      rd_data
);
    import resize_pkg::*;

    // ======================================================================
    // averaged bytes, row-major
    // ======================================================================
    logic [7:0] mem [out_count];

    // single write port from the averager
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr.idx] <= wr.value;
        end
    end

    // registered read, data follows the index by one cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

//--- verilog/byte_sender.sv
module byte_sender (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            avg_done,
    input  logic                            tx_done,
    output logic [resize_pkg::idx_bits-1:0] rd_idx,
    input  logic [7:0]                      rd_data,
    output logic [7:0]                      uart_tx,
    output logic                            uart_trmt,
    output logic                            done
);
    import resize_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_wait,
        st_finish
    } state_t;

    state_t              state;
    // index of the byte held in the buffer read register
    logic [idx_bits-1:0] byte_idx;
    // final byte already handed to the transmitter
    logic                all_sent;
    // edge detectors
    logic                avg_prev;
    logic                tx_q;
    logic                tx_prev;
    logic                tx_rise;

    assign rd_idx  = byte_idx;
    assign tx_rise = tx_q && !tx_prev;

    // ======================================================================
    // send FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            byte_idx  <= '0;
            all_sent  <= 1'b0;
            avg_prev  <= 1'b0;
            tx_q      <= 1'b0;
            tx_prev   <= 1'b0;
            uart_tx   <= '0;
            uart_trmt <= 1'b0;
            done      <= 1'b0;
        end else begin
            avg_prev  <= avg_done;
            // tx_done comes from outside, register before edge detect
            tx_q      <= tx_done;
            tx_prev   <= tx_q;
            // strobes last one cycle
            uart_trmt <= 1'b0;
            done      <= 1'b0;
            case (state)
                st_idle: begin
                    if (avg_done && !avg_prev) begin
                        byte_idx <= '0;
                        all_sent <= 1'b0;
                        state    <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (all_sent) begin
                        // last ack seen
                        done  <= 1'b1;
                        state <= st_finish;
                    end else begin
                        uart_tx   <= rd_data;
                        uart_trmt <= 1'b1;
                        all_sent  <= (byte_idx == idx_bits'(out_count - 1));
                        // prefetch the next byte while waiting
                        byte_idx  <= byte_idx + 1'b1;
                        state     <= st_wait;
                    end
                end
                st_wait: begin
                    if (tx_rise) begin
                        state <= st_fetch;
                    end
                end
                st_finish: begin
                    // once per reset
                    state <= st_finish;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- verilog/image_downscale_top.sv
module image_downscale_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             key_n,
    input  logic [7:0]                       read_data,
    input  logic                             tx_done,
    output logic                             read_en,
    output logic [resize_pkg::addr_bits-1:0] read_addr,
    output logic [7:0]                       uart_tx,
    output logic                             uart_trmt,
    output logic                             frame_loaded,
    output logic                             avg_done,
    output logic                             done
);
    import resize_pkg::*;

    // pixel stream
    pix_beat_t           beat;
    logic                pix_valid;
    // averaged results
    res_wr_t             wr;
    logic                wr_valid;
    // buffer read side
    logic [idx_bits-1:0] rd_idx;
    logic [7:0]          rd_data;

    // ======================================================================
    // datapath: memory -> averager -> buffer -> transmitter
    // ======================================================================
    frame_reader i_frame_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_n        (key_n),
        .read_data    (read_data),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .beat         (beat),
        .pix_valid    (pix_valid),
        .frame_loaded (frame_loaded)
    );

    block_averager i_block_averager (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat      (beat),
        .pix_valid (pix_valid),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .avg_done  (avg_done)
    );

    result_buffer i_result_buffer (
        .clk      (clk),
        .wr       (wr),
        .wr_valid (wr_valid),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    // starts on avg_done, paced by tx_done
    byte_sender i_byte_sender (
        .clk       (clk),
        .rst_n     (rst_n),
        .avg_done  (avg_done),
        .tx_done   (tx_done),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .uart_tx   (uart_tx),
        .uart_trmt (uart_trmt),
        .done      (done)
    );

endmodule

//--- bench/tb_image_downscale.sv
module tb_image_downscale;
    timeunit 1ns;
    timeprecision 100ps;
    import resize_pkg::*;

    typedef enum logic [1:0] {
        fill_const,
        fill_ramp,
        fill_rand
    } fill_t;

    // one row of the stimulus table
    typedef struct packed {
        fill_t      fill_mode;
        logic [7:0] fill_value;
        logic [3:0] tx_delay;
        logic       rand_delay;
        logic       second_press;
    } test_entry_t;

    // DUT ports
    logic                 clk;
    logic                 rst_n;
    logic                 key_n;
    logic [7:0]           read_data;
    logic                 tx_done;
    logic                 read_en;
    logic [addr_bits-1:0] read_addr;
    logic [7:0]           uart_tx;
    logic                 uart_trmt;
    logic                 frame_loaded;
    logic                 avg_done;
    logic                 done;

    // ======================================================================
    // stimulus table
    // ======================================================================
    test_entry_t stim [4] = '{
        '{fill_mode: fill_const, fill_value: 8'h5a, tx_delay: 4'd0,
          rand_delay: 1'b0, second_press: 1'b0},
        '{fill_mode: fill_ramp, fill_value: 8'h11, tx_delay: 4'd3,
          rand_delay: 1'b0, second_press: 1'b0},
        '{fill_mode: fill_rand, fill_value: 8'h00, tx_delay: 4'd0,
          rand_delay: 1'b1, second_press: 1'b1},
        '{fill_mode: fill_const, fill_value: 8'hff, tx_delay: 4'd3,
          rand_delay: 1'b0, second_press: 1'b0}
    };

    // frame image and byte predictions
    logic [7:0]           frame [src_w*src_h];
    logic [7:0]           expected [out_count];
    logic [7:0]           received [out_count];
    test_entry_t          cur;
    int unsigned          lcg_state;
    int unsigned          cycle_count;
    int unsigned          cycle_limit;
    int                   value_errors;
    int                   protocol_errors;
    // per-entry bookkeeping
    int                   addr_count;
    int                   rx_count;
    int                   ack_count;
    int                   done_count;
    int                   delay_left;
    logic                 key_pressed;
    logic [7:0]           last_tx;
    // memory read latched for the one-cycle answer
    logic                 mem_en;
    logic [addr_bits-1:0] mem_addr;

    image_downscale_top i_image_downscale_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_n        (key_n),
        .read_data    (read_data),
        .tx_done      (tx_done),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .uart_tx      (uart_tx),
        .uart_trmt    (uart_trmt),
        .frame_loaded (frame_loaded),
        .avg_done     (avg_done),
        .done         (done)
    );

    always #2 clk = ~clk;

    // LCG step, upper bits are the useful ones
    function automatic int unsigned next_rand(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            value_errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic report_problem(input string what);
        protocol_errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic fill_frame(input test_entry_t e);
        int r;
        int c;
        for (r = 0; r < src_h; r++) begin
            for (c = 0; c < src_w; c++) begin
                case (e.fill_mode)
                    fill_const: frame[r*src_w + c] = e.fill_value;
                    // slope in both directions, wraps at 256
                    fill_ramp: frame[r*src_w + c] = 8'(c*3 + r*5 + e.fill_value);
                    default: begin
                        lcg_state = next_rand(lcg_state);
                        frame[r*src_w + c] = lcg_state[23:16];
                    end
                endcase
            end
        end
    endtask

    // floor of each block sum over the block area, row-major
    task automatic predict_bytes();
        int by;
        int bx;
        int r;
        int c;
        int sum;
        for (by = 0; by < out_h; by++) begin
            for (bx = 0; bx < out_w; bx++) begin
                sum = 0;
                for (r = 0; r < blk_h; r++) begin
                    for (c = 0; c < blk_w; c++) begin
                        sum += frame[(by*blk_h + r)*src_w + bx*blk_w + c];
                    end
                end
                expected[by*out_w + bx] = 8'(sum / blk_area);
            end
        end
    endtask

    // ======================================================================
    // memory and transmitter models, monitors
    // ======================================================================
    always @(posedge clk) begin
        mem_en   <= read_en;
        mem_addr <= read_addr;
    end

    // answer one cycle after the address
    always @(negedge clk) begin
        if (mem_en) begin
            read_data = frame[mem_addr];
        end
    end

    // address sequence
    always @(negedge clk) begin
        if (read_en) begin
            if (!key_pressed) begin
                report_problem("read_en went high before the key press");
            end else if (addr_count >= src_w*src_h) begin
                report_problem("read_en high after the last address");
            end else begin
                check_value("read_addr", addr_count, read_addr);
            end
            addr_count++;
        end
    end

    // byte transmitter, drops tx_done on a strobe and raises it after the delay
    always @(negedge clk) begin
        if (uart_trmt) begin
            if (!avg_done) begin
                report_problem("uart_trmt came before avg_done");
            end
            if (!tx_done) begin
                report_problem("uart_trmt while the previous byte was not acknowledged");
            end
            if (rx_count < out_count) begin
                received[rx_count] = uart_tx;
            end else begin
                report_problem("more bytes sent than the buffer holds");
            end
            rx_count++;
            last_tx = uart_tx;
            tx_done = 1'b0;
            if (cur.rand_delay) begin
                lcg_state = next_rand(lcg_state);
                delay_left = 1 + (lcg_state >> 16) % 9;
            end else begin
                delay_left = cur.tx_delay;
            end
        end else begin
            // byte held between strobes
            if (rx_count > 0) begin
                check_value("uart_tx", last_tx, uart_tx);
            end
            if (!tx_done) begin
                if (delay_left == 0) begin
                    tx_done = 1'b1;
                    ack_count++;
                end else begin
                    delay_left--;
                end
            end
        end
        if (done) begin
            done_count++;
            if (ack_count != out_count) begin
                report_problem("done pulsed before the last acknowledgement");
            end
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the DUT hung, no completion within %0d cycles", cycle_limit);
            $display("errors: %0d value mismatches, %0d protocol errors",
                     value_errors, protocol_errors);
            $display("sim failed");
            $finish;
        end
    end

    // ======================================================================
    // one table entry from reset to completion
    // ======================================================================
    task automatic run_entry(input int n);
        int i;
        cur = stim[n];
        fill_frame(cur);
        predict_bytes();
        @(negedge clk);
        rst_n       = 1'b0;
        key_n       = 1'b1;
        tx_done     = 1'b1;
        addr_count  = 0;
        rx_count    = 0;
        ack_count   = 0;
        done_count  = 0;
        delay_left  = 0;
        key_pressed = 1'b0;
        repeat (2) @(negedge clk);
        // everything quiet in reset
        check_value("read_en", 0, read_en);
        check_value("uart_trmt", 0, uart_trmt);
        check_value("done", 0, done);
        check_value("avg_done", 0, avg_done);
        check_value("frame_loaded", 0, frame_loaded);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        key_n       = 1'b0;
        key_pressed = 1'b1;
        @(negedge clk);
        key_n = 1'b1;
        check_value("read_en", 1, read_en);
        while (done_count == 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value("address count", src_w*src_h, addr_count);
        check_value("frame_loaded", 1, frame_loaded);
        check_value("avg_done", 1, avg_done);
        check_value("done pulses", 1, done_count);
        check_value("bytes sent", out_count, rx_count);
        check_value("acknowledgements", out_count, ack_count);
        for (i = 0; i < out_count; i++) begin
            check_value($sformatf("uart_tx byte %0d", i), expected[i], received[i]);
        end
        // a late key press must not restart anything
        if (cur.second_press) begin
            key_n = 1'b0;
            repeat (2) @(negedge clk);
            key_n = 1'b1;
            repeat (200) begin
                @(negedge clk);
                check_value("read_en", 0, read_en);
                check_value("uart_trmt", 0, uart_trmt);
                check_value("done", 0, done);
            end
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        key_n           = 1'b1;
        read_data       = 8'h00;
        tx_done         = 1'b1;
        mem_en          = 1'b0;
        mem_addr        = '0;
        lcg_state       = 17437;
        cycle_count     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        key_pressed     = 1'b0;
        cur             = stim[0];
        cycle_limit     = $size(stim) * (src_w*src_h + out_count*14 + 200);
        for (int n = 0; n < $size(stim); n++) begin
            run_entry(n);
        end
        $display("errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb.f
verilog/resize_pkg.sv
verilog/frame_reader.sv
verilog/block_averager.sv
verilog/result_buffer.sv
verilog/byte_sender.sv
verilog/image_downscale_top.sv
bench/tb_image_downscale.sv
